// File: src/ara_cfg_pkg.sv
// Vector unit configuration
// Element width, element and lane-index types, and the lane-count limit
package ara_cfg_pkg;

  ////////////////////
  // Elements
  ////////////////////

  // One element per lane, one machine word
  localparam int unsigned ElemWidth = 32;

  typedef logic [ElemWidth-1:0] elem_t;

  // Scalar result returned to the core
  typedef logic [31:0] scalar_t;

  ////////////////////
  // Lanes
  ////////////////////

  // Upper bound on the NrLanes parameter of the top level
  localparam int unsigned MaxNrLanes = 16;

  // Wide enough for a lane index and for a vl of MaxNrLanes
  typedef logic [$clog2(MaxNrLanes+1)-1:0] lane_idx_t;

endpackage : ara_cfg_pkg

// File: src/ara_insn_pkg.sv
// Vector instruction format
// Operation encoding plus the request and response structs
package ara_insn_pkg;

  ////////////////////
  // Operations
  ////////////////////

  typedef enum logic [2:0] {
    // Element-wise integer ops, computed in the lanes
    VADD  = 3'd0,
    VSUB  = 3'd1,
    VAND  = 3'd2,
    VOR   = 3'd3,
    VXOR  = 3'd4,
    // Compares, mask result
    VMSEQ = 3'd5,
    VMSLT = 3'd6,
    // Population count of the active mask, scalar result
    VCPOP = 3'd7
  } ara_op_e;

  ////////////////////
  // Core interface
  ////////////////////

  // Request from the scalar core, vectors travel alongside
  typedef struct packed {
    ara_op_e               op;
    // Mask enable, elements follow v0 when set
    logic                  vm;
    // Vector length in elements
    ara_cfg_pkg::lane_idx_t vl;
  } ara_req_t;

  // Response back to the core
  typedef struct packed {
    ara_op_e              op;
    ara_cfg_pkg::scalar_t scalar;
  } ara_resp_t;

endpackage : ara_insn_pkg

// File: src/ara_skid_buffer.sv
// Skid buffer
// Two-entry valid/ready buffer with registered ready, full throughput
module ara_skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // Upstream
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     out_valid_q;
  payload_t out_data_q;
  logic     skid_valid_q;
  payload_t skid_data_q;
  logic     in_fire;
  logic     out_load;

  // Ready only depends on the skid slot being free
  assign ready_o  = ~skid_valid_q;
  assign in_fire  = valid_i & ready_o;
  // Output register empty or being drained this cycle
  assign out_load = ~out_valid_q | ready_i;

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_load) begin
      out_valid_q  <= skid_valid_q | in_fire;
      skid_valid_q <= 1'b0;
    end else if (in_fire) begin
      // Output stalled, park the new beat
      skid_valid_q <= 1'b1;
    end
  end

  ////////////////////
  // Payload
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (out_load) begin
      out_data_q <= skid_valid_q ? skid_data_q : data_i;
    end else if (in_fire) begin
      skid_data_q <= data_i;
    end
  end

  assign valid_o = out_valid_q;
  assign data_o  = out_data_q;

endmodule : ara_skid_buffer

// File: src/ara_lane.sv
// Vector lane
// Integer ALU for one element pair with its execute-stage result register
module ara_lane (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      en_i,
  input  ara_insn_pkg::ara_op_e     op_i,
  input  ara_cfg_pkg::elem_t        vs1_i,
  input  ara_cfg_pkg::elem_t        vs2_i,
  output ara_cfg_pkg::elem_t        res_o
);

  ara_cfg_pkg::elem_t res_d;
  ara_cfg_pkg::elem_t res_q;

  // Operand order follows the vector ISA, vd = vs2 op vs1
  always_comb begin
    case (op_i)
      ara_insn_pkg::VADD: res_d = vs2_i + vs1_i;
      ara_insn_pkg::VSUB: res_d = vs2_i - vs1_i;
      ara_insn_pkg::VAND: res_d = vs2_i & vs1_i;
      ara_insn_pkg::VOR:  res_d = vs2_i | vs1_i;
      ara_insn_pkg::VXOR: res_d = vs2_i ^ vs1_i;
      // Compares and popcount live in the mask unit
      default:            res_d = '0;
    endcase
  end

  // Execute stage, moves with the mask unit's stage
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res_q <= '0;
    end else if (en_i) begin
      res_q <= res_d;
    end
  end

  assign res_o = res_q;

endmodule : ara_lane

// File: src/ara_masku.sv
// Mask unit
// Active-element mask, compare masks and popcount, plus the
// execute-stage valid flag and the stall control for the whole stage
module ara_masku #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  // From the input buffer
  input  logic                                 valid_i,
  input  ara_insn_pkg::ara_req_t               req_i,
  input  logic               [NrLanes-1:0]     vmask_i,
  input  ara_cfg_pkg::elem_t [NrLanes-1:0]     vs1_i,
  input  ara_cfg_pkg::elem_t [NrLanes-1:0]     vs2_i,
  // Stage control
  input  logic                                 out_ready_i,
  output logic                                 advance_o,
  output logic                                 valid_o,
  // Registered results
  output logic               [NrLanes-1:0]     active_o,
  output logic               [NrLanes-1:0]     cmp_mask_o,
  output ara_cfg_pkg::scalar_t                 popcnt_o
);

  logic                 valid_q;
  logic [NrLanes-1:0]   active_d;
  logic [NrLanes-1:0]   active_q;
  logic [NrLanes-1:0]   cmp_d;
  logic [NrLanes-1:0]   cmp_q;
  ara_cfg_pkg::scalar_t popcnt_d;
  ara_cfg_pkg::scalar_t popcnt_q;

  ////////////////////
  // Stall control
  ////////////////////

  // Stage moves when empty or when the output buffer takes it
  assign advance_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (advance_o) begin
      valid_q <= valid_i;
    end
  end

  ////////////////////
  // Mask logic
  ////////////////////

  always_comb begin
    for (int i = 0; i < NrLanes; i++) begin
      // Body element, and either unmasked or enabled by v0
      active_d[i] = (ara_cfg_pkg::lane_idx_t'(i) < req_i.vl) && (!req_i.vm || vmask_i[i]);
      // vs2 is the left operand, as in vmslt.vv
      case (req_i.op)
        ara_insn_pkg::VMSEQ: cmp_d[i] = (vs2_i[i] == vs1_i[i]);
        ara_insn_pkg::VMSLT: cmp_d[i] = ($signed(vs2_i[i]) < $signed(vs1_i[i]));
        default:             cmp_d[i] = 1'b0;
      endcase
    end
  end

  always_comb begin
    popcnt_d = '0;
    for (int i = 0; i < NrLanes; i++) begin
      popcnt_d = popcnt_d + ara_cfg_pkg::scalar_t'(active_d[i]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance_o) begin
      active_q <= active_d;
      cmp_q    <= cmp_d;
      popcnt_q <= popcnt_d;
    end
  end

  assign valid_o    = valid_q;
  assign active_o   = active_q;
  assign cmp_mask_o = cmp_q;
  assign popcnt_o   = popcnt_q;

endmodule : ara_masku

// File: src/ara_result_merge.sv
// Result merge
// Combines lane results and mask-unit results into the response
module ara_result_merge #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                             clk_i,
  input  logic                             advance_i,
  input  ara_insn_pkg::ara_op_e            op_i,
  input  ara_cfg_pkg::elem_t [NrLanes-1:0] vs2_i,
  input  ara_cfg_pkg::elem_t [NrLanes-1:0] lane_res_i,
  input  logic               [NrLanes-1:0] active_i,
  input  logic               [NrLanes-1:0] cmp_mask_i,
  input  ara_cfg_pkg::scalar_t             popcnt_i,
  output ara_insn_pkg::ara_resp_t          resp_o,
  output ara_cfg_pkg::elem_t [NrLanes-1:0] vd_o,
  output logic               [NrLanes-1:0] mask_o
);

  ara_insn_pkg::ara_op_e            op_q;
  ara_cfg_pkg::elem_t [NrLanes-1:0] vs2_q;
  logic                             is_alu;
  logic                             is_cmp;

  // Execute-stage copies, kept in step with the lanes
  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      op_q  <= op_i;
      vs2_q <= vs2_i;
    end
  end

  assign is_alu = (op_q <= ara_insn_pkg::VXOR);
  assign is_cmp = (op_q == ara_insn_pkg::VMSEQ) || (op_q == ara_insn_pkg::VMSLT);

  // Inactive and tail elements keep vs2
  always_comb begin
    for (int i = 0; i < NrLanes; i++) begin
      vd_o[i] = (is_alu && active_i[i]) ? lane_res_i[i] : vs2_q[i];
    end
  end

  assign mask_o        = is_cmp ? (cmp_mask_i & active_i) : '0;
  assign resp_o.op     = op_q;
  assign resp_o.scalar = (op_q == ara_insn_pkg::VCPOP) ? popcnt_i : '0;

endmodule : ara_result_merge

// File: src/ara.sv
// Vector execution unit top level
// Input buffer, lanes and mask unit side by side, merge, output buffer
module ara #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  // Request from the core
  input  ara_insn_pkg::ara_req_t           acc_req_i,
  input  logic               [NrLanes-1:0] acc_vmask_i,
  input  ara_cfg_pkg::elem_t [NrLanes-1:0] acc_vs1_i,
  input  ara_cfg_pkg::elem_t [NrLanes-1:0] acc_vs2_i,
  input  logic                             acc_req_valid_i,
  output logic                             acc_req_ready_o,
  // Response to the core
  output ara_insn_pkg::ara_resp_t          acc_resp_o,
  output ara_cfg_pkg::elem_t [NrLanes-1:0] acc_resp_vd_o,
  output logic               [NrLanes-1:0] acc_resp_mask_o,
  output logic                             acc_resp_valid_o,
  input  logic                             acc_resp_ready_i
);

  typedef struct packed {
    ara_insn_pkg::ara_req_t           req;
    logic               [NrLanes-1:0] vmask;
    ara_cfg_pkg::elem_t [NrLanes-1:0] vs1;
    ara_cfg_pkg::elem_t [NrLanes-1:0] vs2;
  } in_payload_t;

  typedef struct packed {
    ara_insn_pkg::ara_resp_t          resp;
    ara_cfg_pkg::elem_t [NrLanes-1:0] vd;
    logic               [NrLanes-1:0] mask;
  } out_payload_t;

  in_payload_t                      req_payload;
  in_payload_t                      in_data;
  logic                             in_valid;
  logic                             advance;
  logic                             stage_valid;
  logic                             out_ready;
  ara_cfg_pkg::elem_t [NrLanes-1:0] lane_res;
  logic               [NrLanes-1:0] active;
  logic               [NrLanes-1:0] cmp_mask;
  ara_cfg_pkg::scalar_t             popcnt;
  out_payload_t                     resp_payload;
  out_payload_t                     out_data;

  ////////////////////
  // Input buffer
  ////////////////////

  assign req_payload.req   = acc_req_i;
  assign req_payload.vmask = acc_vmask_i;
  assign req_payload.vs1   = acc_vs1_i;
  assign req_payload.vs2   = acc_vs2_i;

  ara_skid_buffer #(
    .payload_t(in_payload_t)
  ) i_in_buffer (
    .clk_i  (clk_i          ),
    .rst_i  (rst_i          ),
    .valid_i(acc_req_valid_i),
    .ready_o(acc_req_ready_o),
    .data_i (req_payload    ),
    .valid_o(in_valid       ),
    .ready_i(advance        ),
    .data_o (in_data        )
  );

  ////////////////////
  // Execute stage
  ////////////////////

  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_lanes
    ara_lane i_lane (
      .clk_i(clk_i             ),
      .rst_i(rst_i             ),
      .en_i (advance           ),
      .op_i (in_data.req.op    ),
      .vs1_i(in_data.vs1[lane] ),
      .vs2_i(in_data.vs2[lane] ),
      .res_o(lane_res[lane]    )
    );
  end : gen_lanes

  ara_masku #(
    .NrLanes(NrLanes)
  ) i_masku (
    .clk_i      (clk_i        ),
    .rst_i      (rst_i        ),
    .valid_i    (in_valid     ),
    .req_i      (in_data.req  ),
    .vmask_i    (in_data.vmask),
    .vs1_i      (in_data.vs1  ),
    .vs2_i      (in_data.vs2  ),
    .out_ready_i(out_ready    ),
    .advance_o  (advance      ),
    .valid_o    (stage_valid  ),
    .active_o   (active       ),
    .cmp_mask_o (cmp_mask     ),
    .popcnt_o   (popcnt       )
  );

  ara_result_merge #(
    .NrLanes(NrLanes)
  ) i_merge (
    .clk_i     (clk_i            ),
    .advance_i (advance          ),
    .op_i      (in_data.req.op   ),
    .vs2_i     (in_data.vs2      ),
    .lane_res_i(lane_res         ),
    .active_i  (active           ),
    .cmp_mask_i(cmp_mask         ),
    .popcnt_i  (popcnt           ),
    .resp_o    (resp_payload.resp),
    .vd_o      (resp_payload.vd  ),
    .mask_o    (resp_payload.mask)
  );

  ////////////////////
  // Output buffer
  ////////////////////

  ara_skid_buffer #(
    .payload_t(out_payload_t)
  ) i_out_buffer (
    .clk_i  (clk_i           ),
    .rst_i  (rst_i           ),
    .valid_i(stage_valid     ),
    .ready_o(out_ready       ),
    .data_i (resp_payload    ),
    .valid_o(acc_resp_valid_o),
    .ready_i(acc_resp_ready_i),
    .data_o (out_data        )
  );

  assign acc_resp_o      = out_data.resp;
  assign acc_resp_vd_o   = out_data.vd;
  assign acc_resp_mask_o = out_data.mask;

  // Elaboration checks on the lane count
  if (NrLanes == 0) begin : gen_chk_zero
    $error("ara needs at least one lane");
  end
  if (NrLanes != 2**$clog2(NrLanes)) begin : gen_chk_pow2
    $error("ara lane count must be a power of two");
  end
  if (NrLanes > ara_cfg_pkg::MaxNrLanes) begin : gen_chk_max
    $error("ara lane count exceeds MaxNrLanes");
  end

endmodule : ara

// File: dv/ara_sva.sv
// Response checker for the vector unit
// Reference model of the merge rule, in-order scoreboard and handshake assertions
module ara_sva #(
  parameter int unsigned NrLanes = 4
) (
  input logic                             clk_i,
  input logic                             rst_i,
  input ara_insn_pkg::ara_req_t           acc_req_i,
  input logic               [NrLanes-1:0] acc_vmask_i,
  input ara_cfg_pkg::elem_t [NrLanes-1:0] acc_vs1_i,
  input ara_cfg_pkg::elem_t [NrLanes-1:0] acc_vs2_i,
  input logic                             acc_req_valid_i,
  input logic                             acc_req_ready_o,
  input ara_insn_pkg::ara_resp_t          acc_resp_o,
  input ara_cfg_pkg::elem_t [NrLanes-1:0] acc_resp_vd_o,
  input logic               [NrLanes-1:0] acc_resp_mask_o,
  input logic                             acc_resp_valid_o,
  input logic                             acc_resp_ready_i
);

  // Up to five in flight, rounded up
  localparam int unsigned Depth = 8;

  typedef struct packed {
    ara_insn_pkg::ara_resp_t          resp;
    ara_cfg_pkg::elem_t [NrLanes-1:0] vd;
    logic               [NrLanes-1:0] mask;
    // Cycle of the accepting edge
    logic               [31:0]        cycle;
  } exp_t;

  exp_t        model;
  exp_t        exp_q [Depth];
  exp_t        head;
  logic [2:0]  wr_ptr;
  logic [2:0]  rd_ptr;
  logic [3:0]  count;
  logic [31:0] cycle_cnt;
  logic [31:0] last_low;
  logic        req_fire;
  logic        resp_fire;
  int unsigned err_cnt = 0;

  assign req_fire  = acc_req_valid_i & acc_req_ready_o;
  assign resp_fire = acc_resp_valid_o & acc_resp_ready_i;
  assign head      = exp_q[rd_ptr];

  ////////////////////
  // Reference model
  ////////////////////

  always_comb begin
    logic               act;
    ara_cfg_pkg::elem_t alu;
    model         = '0;
    model.resp.op = acc_req_i.op;
    model.cycle   = cycle_cnt;
    for (int i = 0; i < NrLanes; i++) begin
      act = (i < int'(acc_req_i.vl)) && (!acc_req_i.vm || acc_vmask_i[i]);
      case (acc_req_i.op)
        ara_insn_pkg::VADD: alu = acc_vs2_i[i] + acc_vs1_i[i];
        ara_insn_pkg::VSUB: alu = acc_vs2_i[i] - acc_vs1_i[i];
        ara_insn_pkg::VAND: alu = acc_vs2_i[i] & acc_vs1_i[i];
        ara_insn_pkg::VOR:  alu = acc_vs2_i[i] | acc_vs1_i[i];
        ara_insn_pkg::VXOR: alu = acc_vs2_i[i] ^ acc_vs1_i[i];
        // Mask-producing ops leave vd as vs2
        default:            alu = acc_vs2_i[i];
      endcase
      model.vd[i] = act ? alu : acc_vs2_i[i];
      if (acc_req_i.op == ara_insn_pkg::VMSEQ) begin
        model.mask[i] = act && (acc_vs2_i[i] == acc_vs1_i[i]);
      end
      if (acc_req_i.op == ara_insn_pkg::VMSLT) begin
        model.mask[i] = act && ($signed(acc_vs2_i[i]) < $signed(acc_vs1_i[i]));
      end
      if (acc_req_i.op == ara_insn_pkg::VCPOP && act) begin
        model.resp.scalar = model.resp.scalar + 1;
      end
    end
  end

  // In-order scoreboard, plus the last cycle the core stalled the response
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      cycle_cnt <= '0;
      last_low  <= '0;
    end else begin
      if (req_fire) begin
        exp_q[wr_ptr] <= model;
        wr_ptr        <= wr_ptr + 3'd1;
      end
      if (resp_fire) begin
        rd_ptr <= rd_ptr + 3'd1;
      end
      count     <= count + 4'(req_fire) - 4'(resp_fire);
      cycle_cnt <= cycle_cnt + 1;
      if (!acc_resp_ready_i) begin
        last_low <= cycle_cnt;
      end
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  a_ready_after_reset: assert property (@(posedge clk_i) $fell(rst_i) |-> acc_req_ready_o)
    else begin
      $error("FAILED ready_after_reset expected 1 actual %b", $sampled(acc_req_ready_o));
      err_cnt++;
    end

  // Full request rate once every skid slot has drained
  a_full_rate: assert property (@(posedge clk_i) disable iff (rst_i)
    (last_low + 4 <= cycle_cnt) |-> acc_req_ready_o)
    else begin
      $error("FAILED req_full_rate expected 1 actual %b", $sampled(acc_req_ready_o));
      err_cnt++;
    end

  a_no_spurious: assert property (@(posedge clk_i) disable iff (rst_i)
    (count == '0) |-> !acc_resp_valid_o)
    else begin
      $error("Response valid with no request outstanding");
      err_cnt++;
    end

  a_resp: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_fire |-> (acc_resp_o == head.resp))
    else begin
      $error("FAILED resp_op_scalar expected %h actual %h",
             $sampled(head.resp), $sampled(acc_resp_o));
      err_cnt++;
    end

  a_vd: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_fire |-> (acc_resp_vd_o == head.vd))
    else begin
      $error("FAILED resp_vd expected %h actual %h", $sampled(head.vd), $sampled(acc_resp_vd_o));
      err_cnt++;
    end

  a_mask: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_fire |-> (acc_resp_mask_o == head.mask))
    else begin
      $error("FAILED resp_mask expected %h actual %h",
             $sampled(head.mask), $sampled(acc_resp_mask_o));
      err_cnt++;
    end

  // Only timed when the core kept ready high long enough to drain all skid slots
  a_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    (resp_fire && (last_low + 4 <= head.cycle)) |-> (cycle_cnt - head.cycle == 3))
    else begin
      $error("FAILED resp_latency expected 3 actual %0d", $sampled(cycle_cnt - head.cycle));
      err_cnt++;
    end

  a_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (acc_resp_valid_o && !acc_resp_ready_i) |=>
      (acc_resp_valid_o && $stable(acc_resp_o) && $stable(acc_resp_vd_o)
       && $stable(acc_resp_mask_o)))
    else begin
      $error("Response changed or dropped while stalled");
      err_cnt++;
    end

endmodule : ara_sva

bind ara ara_sva #(
  .NrLanes(NrLanes)
) u_sva (
  .clk_i           (clk_i           ),
  .rst_i           (rst_i           ),
  .acc_req_i       (acc_req_i       ),
  .acc_vmask_i     (acc_vmask_i     ),
  .acc_vs1_i       (acc_vs1_i       ),
  .acc_vs2_i       (acc_vs2_i       ),
  .acc_req_valid_i (acc_req_valid_i ),
  .acc_req_ready_o (acc_req_ready_o ),
  .acc_resp_o      (acc_resp_o      ),
  .acc_resp_vd_o   (acc_resp_vd_o   ),
  .acc_resp_mask_o (acc_resp_mask_o ),
  .acc_resp_valid_o(acc_resp_valid_o),
  .acc_resp_ready_i(acc_resp_ready_i)
);

// File: dv/ara_tb.sv
// Testbench for the vector execution unit
// Random requests through directed phases, checked by the bound ara_sva
module ara_tb;

  localparam int unsigned NrLanes     = 4;
  localparam int unsigned ResetCycles = 16;
  localparam int unsigned NumTxn      = 200;
  localparam logic [31:0] Seed        = 32'he0ee_54a4;

  logic                             clk;
  logic                             rst;
  ara_insn_pkg::ara_req_t           acc_req;
  logic               [NrLanes-1:0] acc_vmask;
  ara_cfg_pkg::elem_t [NrLanes-1:0] acc_vs1;
  ara_cfg_pkg::elem_t [NrLanes-1:0] acc_vs2;
  logic                             req_valid;
  logic                             req_ready;
  ara_insn_pkg::ara_resp_t          resp;
  ara_cfg_pkg::elem_t [NrLanes-1:0] resp_vd;
  logic               [NrLanes-1:0] resp_mask;
  logic                             resp_valid;
  logic                             resp_ready;

  logic [31:0] stim_state;
  logic [31:0] rdy_state;
  logic        rand_ready = 1'b0;
  int unsigned sent       = 0;
  int unsigned received   = 0;
  int unsigned mismatch;
  int unsigned assert_errs;

  ara #(
    .NrLanes(NrLanes)
  ) u_ara (
    .clk_i           (clk       ),
    .rst_i           (rst       ),
    .acc_req_i       (acc_req   ),
    .acc_vmask_i     (acc_vmask ),
    .acc_vs1_i       (acc_vs1   ),
    .acc_vs2_i       (acc_vs2   ),
    .acc_req_valid_i (req_valid ),
    .acc_req_ready_o (req_ready ),
    .acc_resp_o      (resp      ),
    .acc_resp_vd_o   (resp_vd   ),
    .acc_resp_mask_o (resp_mask ),
    .acc_resp_valid_o(resp_valid),
    .acc_resp_ready_i(resp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_stim();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  // One request from an op range, held until the DUT takes it
  task automatic send_random(input int unsigned op_lo, input int unsigned op_hi,
                             input logic masked);
    logic [2:0] op_bits;
    op_bits = 3'(op_lo + next_stim() % (op_hi - op_lo + 1));
    @(negedge clk);
    acc_req.op = ara_insn_pkg::ara_op_e'(op_bits);
    acc_req.vm = masked & next_stim() % 2 == 1;
    acc_req.vl = masked ? ara_cfg_pkg::lane_idx_t'(next_stim() % (NrLanes + 1))
                        : ara_cfg_pkg::lane_idx_t'(NrLanes);
    acc_vmask  = NrLanes'(next_stim());
    for (int i = 0; i < NrLanes; i++) begin
      acc_vs1[i] = next_stim();
      acc_vs2[i] = next_stim();
      // Some equal pairs so VMSEQ sees both outcomes
      if (next_stim() % 4 == 0) begin
        acc_vs1[i] = acc_vs2[i];
      end
    end
    req_valid = 1'b1;
    // Ready is registered, so its value here decides the next edge
    while (!req_ready) begin
      @(negedge clk);
    end
    sent++;
  endtask

  task automatic go_idle(input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk);
      req_valid = 1'b0;
    end
  endtask

  // Core side of the response handshake
  initial begin
    rdy_state  = Seed ^ 32'h9e37_79b9;
    resp_ready = 1'b1;
    forever begin
      @(negedge clk);
      rdy_state  = xorshift32(rdy_state);
      resp_ready = rand_ready ? rdy_state[0] : 1'b1;
      if (!rst && resp_valid && resp_ready) begin
        received++;
      end
    end
  end

  initial begin
    repeat (NumTxn * 20 + ResetCycles) @(posedge clk);
    $display("Timeout after %0d cycles, %0d of %0d responses seen",
             NumTxn * 20 + ResetCycles, received, sent);
    $display("Testbench failed");
    $finish;
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    stim_state = Seed;
    rst        = 1'b1;
    req_valid  = 1'b0;
    acc_req    = '0;
    acc_vmask  = '0;
    acc_vs1    = '0;
    acc_vs2    = '0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // Idle window after reset
    go_idle(6);
    // Unmasked ALU ops over the full length
    repeat (20) send_random(int'(ara_insn_pkg::VADD), int'(ara_insn_pkg::VXOR), 1'b0);
    go_idle(2);
    // Masked ALU ops and short vl
    repeat (30) send_random(int'(ara_insn_pkg::VADD), int'(ara_insn_pkg::VXOR), 1'b1);
    go_idle(2);
    // Compares and popcount
    repeat (30) send_random(int'(ara_insn_pkg::VMSEQ), int'(ara_insn_pkg::VCPOP), 1'b1);
    go_idle(4);
    // Back to back with the core always ready
    repeat (40) send_random(int'(ara_insn_pkg::VADD), int'(ara_insn_pkg::VCPOP), 1'b1);
    go_idle(4);
    // Random back-pressure and random gaps
    rand_ready = 1'b1;
    repeat (80) begin
      send_random(int'(ara_insn_pkg::VADD), int'(ara_insn_pkg::VCPOP), 1'b1);
      if (next_stim() % 4 == 0) begin
        go_idle(1 + next_stim() % 3);
      end
    end
    go_idle(1);
    wait (received == sent);
    rand_ready = 1'b0;
    go_idle(10);
    assert_errs = u_ara.u_sva.err_cnt;
    mismatch    = (received > sent) ? received - sent : sent - received;
    $display("Errors: %0d assertion failures, %0d missing or extra responses (%0d sent)",
             assert_errs, mismatch, sent);
    if (assert_errs == 0 && mismatch == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : ara_tb

// File: ara.f
src/ara_cfg_pkg.sv
src/ara_insn_pkg.sv
src/ara_skid_buffer.sv
src/ara_lane.sv
src/ara_masku.sv
src/ara_result_merge.sv
src/ara.sv
dv/ara_sva.sv
dv/ara_tb.sv

// File: run.sh
#!/bin/sh
# Build the vector unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ara_tb -f ara.f

# Assertion errors must not stop the run before the closing report
./obj_dir/Vara_tb +verilator+error+limit+100000 \
  | tee /dev/stderr \
  | grep -x "Testbench passed" > /dev/null

echo "Simulation run complete"
